/* packet_link.f */
verilog/link_pkg.sv
verilog/fifo_pkg.sv
verilog/mem_dual_port.sv
verilog/fifo_sync.sv
verilog/credit_sender.sv
verilog/packet_link.sv
tb/packet_link_properties.sv
tb/tb_packet_link.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the packet_link simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module tb_packet_link \
   -f packet_link.f \
   -o sim_packet_link

# a failing run exits nonzero, keep going so the log gets searched
./obj_dir/sim_packet_link > sim.log 2>&1 || true
cat sim.log

if grep -qxF "All tests passed!" sim.log; then
   echo "RESULT: PASS"
else
   echo "RESULT: FAIL"
   exit 1
fi

/* tb/tb_packet_link.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_packet_link
   import link_pkg::*;
   import fifo_pkg::*;
();

   localparam int CLK_HALF      = 2;              // 4 ns period
   localparam int RESET_CYCLES  = 16;
   localparam int SETTLE_CYCLES = 40;             // max wait for a row's packets
   localparam int IDLE_CYCLES   = 8;              // quiet time to catch extra sends
   localparam int ROWS          = 9;

   typedef struct packed
   {
      int   burst;                               // packets written
      int   credits;                             // credit_down pulses
      logic clr;                                 // clear before the row
      int   exp_out;                             // packets delivered in row
      int   exp_up;                              // credit_up pulses in row
      logic exp_af;                              // almost_full at row end
      logic exp_ovf;                             // overflow at row end
   } row_t;

   row_t rows [ROWS] = '{
      '{ 8,  0, 1'b0,  4,  4, 1'b0, 1'b0},       // reset window stops at 4
      '{ 0,  3, 1'b0,  3,  3, 1'b0, 1'b0},       // one packet per credit
      '{13,  0, 1'b0,  0,  0, 1'b1, 1'b0},       // fill to 14
      '{ 0,  1, 1'b0,  1,  1, 1'b0, 1'b0},       // back to 13
      '{ 4,  0, 1'b0,  0,  0, 1'b1, 1'b1},       // one past depth drops the last
      '{ 0,  6, 1'b0,  6,  6, 1'b0, 1'b1},       // drain some while the flag stays
      '{ 6,  0, 1'b1,  4,  4, 1'b0, 1'b0},       // clear first then act as after reset
      '{40, 40, 1'b0, 40, 40, 1'b0, 1'b0},       // write and pop together
      '{ 0,  2, 1'b0,  2,  2, 1'b0, 1'b0}        // drain leftovers
   };

   logic        clk;
   logic        nreset;
   logic        clear;
   logic        in_valid;
   packet_t     in_packet;
   logic        credit_down;
   logic        out_valid;
   packet_t     out_packet;
   logic        credit_up;
   logic        almost_full;
   logic        overflow;

   packet_t     expect_q [$];                    // accepted packets oldest first
   int          n_accepted;                      // writes taken since clear
   int          n_popped;                        // credit_up pulses since clear
   int          row_out;
   int          row_up;
   logic [31:0] lcg_state  = 32'd67;

   packet_link u_packet_link (
      .clk         (clk),
      .nreset      (nreset),
      .clear       (clear),
      .in_valid    (in_valid),
      .in_packet   (in_packet),
      .credit_up   (credit_up),
      .out_valid   (out_valid),
      .out_packet  (out_packet),
      .credit_down (credit_down),
      .almost_full (almost_full),
      .overflow    (overflow)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_HALF) clk = ~clk;
   end

   // ####################################################################
   // helpers
   // ####################################################################

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic packet_t make_packet();
      logic [127:0] wide;
      wide = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      return wide[PACKET_W-1:0];                 // low 104 bits
   endfunction

   function automatic int row_span(input int r);
      return (rows[r].burst > rows[r].credits) ? rows[r].burst : rows[r].credits;
   endfunction

   function automatic int run_limit_ns();
      int cycles;
      int r;
      cycles = RESET_CYCLES;
      for (r = 0; r < ROWS; r++)
         cycles += row_span(r) + SETTLE_CYCLES + IDLE_CYCLES + 2;
      return cycles * 2 * CLK_HALF * 2;          // margin of two
   endfunction

   task automatic check_equal(input packet_t actual, input packet_t expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h",
                  $time, what, actual, expected);
         $display("Test failures found");
         $fatal(1, "stopping at first error");
      end
   endtask

   // ####################################################################
   // output monitor and reference queue
   // ####################################################################

   always @(negedge clk)
   begin
      if (nreset)
      begin
         if (credit_up)
         begin
            n_popped++;                          // entry left the fifo
            row_up++;
         end
         if (out_valid)
         begin
            if (expect_q.size() == 0)
            begin
               $display("A packet came out at %0t ns with none outstanding", $time);
               $display("Test failures found");
               $fatal(1, "unexpected packet");
            end
            else
            begin
               check_equal(out_packet, expect_q.pop_front(), "out_packet order/contents");
               row_out++;
            end
         end
      end
   end

   task automatic apply_row(input int r);
      int      span;
      int      i;
      int      waited;
      packet_t pkt;
      span    = row_span(r);
      row_out = 0;
      row_up  = 0;
      if (rows[r].clr)
      begin
         clear = 1'b1;                           // one cycle flush
         @(posedge clk);
         #1;
         clear = 1'b0;
         expect_q.delete();
         n_accepted = 0;
         n_popped   = 0;
      end
      for (i = 0; i < span; i++)
      begin
         in_valid    = (i < rows[r].burst);
         credit_down = (i < rows[r].credits);
         if (i < rows[r].burst)
         begin
            pkt       = make_packet();
            in_packet = pkt;
            if (n_accepted - n_popped < FIFO_DEPTH) // dropped unless there is room
            begin
               expect_q.push_back(pkt);
               n_accepted++;
            end
         end
         @(posedge clk);
         #1;
      end
      in_valid    = 1'b0;
      credit_down = 1'b0;
      waited      = 0;
      while (row_out < rows[r].exp_out && waited < SETTLE_CYCLES)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      repeat (IDLE_CYCLES) @(posedge clk);       // nothing more may leave
      #1;
      check_equal(packet_t'(row_out), packet_t'(rows[r].exp_out),
                  $sformatf("row %0d packets delivered", r));
      check_equal(packet_t'(row_up), packet_t'(rows[r].exp_up),
                  $sformatf("row %0d credit_up pulses", r));
      check_equal(packet_t'(almost_full), packet_t'(rows[r].exp_af),
                  $sformatf("row %0d almost_full", r));
      check_equal(packet_t'(overflow), packet_t'(rows[r].exp_ovf),
                  $sformatf("row %0d overflow", r));
   endtask

   // ####################################################################
   // main sequence and watchdog
   // ####################################################################

   initial
   begin : main
      int r;
      nreset      = 1'b0;
      clear       = 1'b0;
      in_valid    = 1'b0;
      in_packet   = '0;
      credit_down = 1'b0;
      n_accepted  = 0;
      n_popped    = 0;
      row_out     = 0;
      row_up      = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      nreset = 1'b1;
      @(negedge clk);                            // quiet state after reset
      check_equal(packet_t'(out_valid), '0, "out_valid after reset");
      check_equal(packet_t'(credit_up), '0, "credit_up after reset");
      check_equal(packet_t'(almost_full), '0, "almost_full after reset");
      check_equal(packet_t'(overflow), '0, "overflow after reset");
      @(posedge clk);
      #1;
      for (r = 0; r < ROWS; r++)
         apply_row(r);
      $display("All tests passed!");
      $finish;
   end

   initial
   begin : watchdog
      int limit_ns;
      limit_ns = run_limit_ns();
      #(limit_ns);
      $display("Watchdog expired after %0d ns, the run did not finish", limit_ns);
      $display("Test failures found");
      $fatal(1, "watchdog timeout");
   end

endmodule

`default_nettype wire

/* tb/packet_link_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module packet_link_properties
   import link_pkg::*;
(
   input  logic    clk,
   input  logic    nreset,
   input  logic    clear,
   input  logic    pop,                          // fifo read strobe
   input  credit_t credits,                      // sender credit counter
   input  logic    out_valid,
   input  logic    overflow,
   input  logic    full,                         // fifo full flag
   input  logic    empty                         // fifo empty flag with late fall
);

   // ####################################################################
   // credit rules
   // ####################################################################

   a_pop_needs_credit : assert property (@(posedge clk) disable iff (!nreset)
      pop |-> (credits != '0))
      else $error("pop issued while downstream credits are zero");

   a_out_after_pop : assert property (@(posedge clk) disable iff (!nreset)
      pop |=> out_valid)                         // registered read port
      else $error("out_valid missing one cycle after pop");

   // ####################################################################
   // fifo status rules
   // ####################################################################

   a_overflow_sticky : assert property (@(posedge clk) disable iff (!nreset)
      $fell(overflow) |-> $past(clear))          // only clear may drop it
      else $error("overflow fell without clear or reset");

   a_full_empty_apart : assert property (@(posedge clk) disable iff (!nreset)
      !(full && empty))
      else $error("fifo full and empty at the same time");

endmodule

bind packet_link packet_link_properties u_props (
   .clk       (clk),
   .nreset    (nreset),
   .clear     (clear),
   .pop       (pop),
   .credits   (u_sender.credits),
   .out_valid (out_valid),
   .overflow  (overflow),
   .full      (u_fifo.full),
   .empty     (fifo_empty)
);

`default_nettype wire

/* verilog/packet_link.sv */
`timescale 1ns/10ps
`default_nettype none

module packet_link
   import link_pkg::*;
(
   input  logic    clk,
   input  logic    nreset,
   input  logic    clear,                        // sync flush and credit reload

   // upstream side
   input  logic    in_valid,                     // one packet per cycle
   input  packet_t in_packet,
   output logic    credit_up,                    // one pulse per freed entry

   // downstream side
   output logic    out_valid,
   output packet_t out_packet,
   input  logic    credit_down,                  // one pulse per returned credit

   // status
   output logic    almost_full,
   output logic    overflow                      // sticky until clear/reset
);

   // ####################################################################
   // internal wiring
   // ####################################################################

   logic fifo_empty;                             // fifo to sender
   logic pop;                                    // sender to fifo read

   assign credit_up = pop;                       // entry freed on pop

   // ####################################################################
   // packet buffer
   // ####################################################################

   fifo_sync #(
      .DW  (PACKET_W),
      .REG (1)                                   // registered read only
   ) u_fifo (
      .clk         (clk),
      .nreset      (nreset),
      .clear       (clear),
      .wr_en       (in_valid),
      .wr_data     (in_packet),
      .rd_en       (pop),
      .rd_data     (out_packet),
      .rd_valid    (out_valid),                  // one cycle after pop
      .empty       (fifo_empty),
      .full        (),
      .almost_full (almost_full),
      .overflow    (overflow),
      .count       ()
   );

   // ####################################################################
   // downstream flow control
   // ####################################################################

   credit_sender u_sender (
      .clk         (clk),
      .nreset      (nreset),
      .clear       (clear),
      .empty       (fifo_empty),
      .credit_down (credit_down),
      .pop         (pop),
      .credits     ()
   );

endmodule

`default_nettype wire

/* verilog/credit_sender.sv */
`timescale 1ns/10ps
`default_nettype none

module credit_sender
   import link_pkg::*;
(
   input  logic    clk,
   input  logic    nreset,
   input  logic    clear,                        // sync reload
   input  logic    empty,                        // fifo empty flag
   input  logic    credit_down,                  // one credit back from receiver
   output logic    pop,                          // fifo read, also credit_up
   output credit_t credits                       // downstream credits held
);

   localparam credit_t CREDITS_INIT = credit_t'(OUT_CREDITS);

   logic have_credit;                            // at least one credit
   logic take;                                   // credit spent this cycle
   logic give;                                   // credit returned this cycle

   // ####################################################################
   // send decision
   // ####################################################################

   assign have_credit = (credits != '0);

   // no pop and no credit_up while clear flushes the buffer
   assign pop = ~empty & have_credit & ~clear;

   assign take = pop;
   assign give = credit_down;

   // ####################################################################
   // credit counter
   // ####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         credits <= CREDITS_INIT;                // full window after reset
      end
      else if (clear)
      begin
         credits <= CREDITS_INIT;                // restore window
      end
      else
      begin
         case ({take, give})
            2'b10:
            begin
               credits <= credits - 1'b1;        // packet sent
            end
            2'b01:
            begin
               credits <= credits + 1'b1;        // receiver freed a slot
            end
            default:
            begin
               credits <= credits;               // spend and return cancel
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/fifo_sync.sv */
`timescale 1ns/10ps
`default_nettype none

module fifo_sync
   import fifo_pkg::*;
#(
   parameter int DW  = 104,                      // word width
   parameter int REG = 1                         // registered memory output
)
(
   input  logic          clk,
   input  logic          nreset,
   input  logic          clear,                  // sync flush
   input  logic          wr_en,                  // push request
   input  logic [DW-1:0] wr_data,
   input  logic          rd_en,                  // pop request
   output logic [DW-1:0] rd_data,
   output logic          rd_valid,               // rd_data qualifier
   output logic          empty,
   output logic          full,
   output logic          almost_full,
   output logic          overflow,               // sticky on write at full
   output fifo_count_t   count                   // occupancy
);

   fifo_ptr_t  wr_ptr;                           // write pointer with wrap bit
   fifo_ptr_t  rd_ptr;                           // read pointer with wrap bit
   fifo_addr_t wr_addr;
   fifo_addr_t rd_addr;
   logic       ptr_match;                        // same slot
   logic       ptr_empty;                        // empty from pointers alone
   logic       fifo_write;                       // accepted write
   logic       fifo_read;                        // accepted read

   // ####################################################################
   // pointer compare and flags
   // ####################################################################

   assign wr_addr   = wr_ptr[FIFO_AW-1:0];
   assign rd_addr   = rd_ptr[FIFO_AW-1:0];
   assign ptr_match = (wr_addr == rd_addr);
   assign full      = ptr_match & (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]); // wrapped once
   assign ptr_empty = ptr_match & (wr_ptr[FIFO_AW] == rd_ptr[FIFO_AW]);

   assign fifo_write = wr_en & ~full;            // drop writes at full
   assign fifo_read  = rd_en & ~ptr_empty;       // ignore reads at empty

   assign almost_full = (count >= fifo_count_t'(ALMOST_FULL_LEVEL));

   // pointers and occupancy
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (clear)
      begin
         wr_ptr <= '0;                           // flush contents
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (fifo_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo_read)
            rd_ptr <= rd_ptr + 1'b1;
         case ({fifo_write, fifo_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;             // both or neither
         endcase
      end
   end

   // sticky overflow when the sender breaks the credit contract
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         overflow <= 1'b0;
      else if (clear)
         overflow <= 1'b0;
      else if (wr_en & full)
         overflow <= 1'b1;
   end

   // ####################################################################
   // empty delayed on its falling side to cover the output register
   // ####################################################################

   generate
      if (REG != 0)
      begin : g_empty_reg
         logic empty_q;

         always_ff @(posedge clk or negedge nreset)
         begin
            if (!nreset)
               empty_q <= 1'b1;
            else if (clear)
               empty_q <= 1'b1;
            else
               empty_q <= ptr_empty;
         end

         assign empty = empty_q | ptr_empty;     // rises at once and falls late
      end
      else
      begin : g_empty_comb
         assign empty = ptr_empty;
      end
   endgenerate

   mem_dual_port #(
      .DW    (DW),
      .DEPTH (FIFO_DEPTH),
      .REG   (REG)
   ) u_mem (
      .clk      (clk),
      .nreset   (nreset),
      .wr_en    (fifo_write),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .rd_en    (fifo_read),
      .rd_addr  (rd_addr),
      .discard  (clear),                         // clear kills read in flight
      .rd_data  (rd_data),
      .rd_valid (rd_valid)
   );

endmodule

`default_nettype wire

/* verilog/mem_dual_port.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_dual_port
   import fifo_pkg::*;
#(
   parameter int DW    = 104,                    // word width
   parameter int DEPTH = 16,                     // number of words
   parameter int REG   = 1                       // registered read port
)
(
   input  logic          clk,
   input  logic          nreset,
   input  logic          wr_en,                  // write whole word
   input  fifo_addr_t    wr_addr,
   input  logic [DW-1:0] wr_data,
   input  logic          rd_en,                  // read strobe
   input  fifo_addr_t    rd_addr,
   input  logic          discard,                // drop read in flight
   output logic [DW-1:0] rd_data,
   output logic          rd_valid                // rd_data qualifier
);

   logic [DW-1:0] ram [DEPTH];                   // storage array

   always_ff @(posedge clk)
   begin
      if (wr_en)
         ram[wr_addr] <= wr_data;                // full word write
   end

   generate
      if (REG != 0)
      begin : g_rd_reg
         always_ff @(posedge clk)
         begin
            if (rd_en)
               rd_data <= ram[rd_addr];          // payload register
         end

         always_ff @(posedge clk or negedge nreset)
         begin
            if (!nreset)
               rd_valid <= 1'b0;
            else
               rd_valid <= rd_en & ~discard;     // one cycle after read
         end
      end
      else
      begin : g_rd_comb
         assign rd_data  = ram[rd_addr];         // same-cycle read
         assign rd_valid = rd_en & ~discard;
      end
   endgenerate

endmodule

`default_nettype wire

/* verilog/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

   // ####################################################################
   // buffer geometry
   // ####################################################################

   localparam int FIFO_DEPTH = 16;               // entries
   localparam int FIFO_AW    = 4;                // log2 of depth

   typedef logic [FIFO_AW-1:0] fifo_addr_t;      // memory address
   typedef logic [FIFO_AW:0]   fifo_ptr_t;       // address plus wrap bit
   typedef logic [FIFO_AW:0]   fifo_count_t;     // occupancy 0..FIFO_DEPTH

   // ####################################################################
   // status thresholds
   // ####################################################################

   // almost_full is high from this occupancy upward
   localparam int ALMOST_FULL_LEVEL = 14;

endpackage

`default_nettype wire

/* verilog/link_pkg.sv */
`default_nettype none

package link_pkg;

   // ####################################################################
   // packet format
   // ####################################################################

   localparam int PACKET_W = 104;                // one mesh packet

   typedef logic [PACKET_W-1:0] packet_t;        // in/out packet and fifo word

   // ####################################################################
   // downstream credit sizing
   // ####################################################################

   localparam int OUT_CREDITS = 4;               // credits held after reset/clear
   localparam int CREDIT_W    = 3;               // holds 0..OUT_CREDITS

   typedef logic [CREDIT_W-1:0] credit_t;        // credit counter

endpackage

`default_nettype wire
